/* sv32_mmu.f */
hw/mmu_pkg.sv
hw/mmu_ctrl_regs.sv
hw/tlb.sv
hw/pte_check.sv
hw/page_walker.sv
hw/sv32_mmu.sv
test/mem_model.sv
test/sv32_mmu_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= sv32_mmu_tb
RTL_TOP   ?= sv32_mmu
FILELIST  ?= sv32_mmu.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^test passed$$"

clean:
	rm -rf $(OBJ_DIR)

/* test/sv32_mmu_tb.sv */
////////////////////////////////////////////////////////////
// testbench for sv32_mmu: bypass, 4K and megapage walks,
// faults, TLB reuse and flush, credit back-pressure
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sv32_mmu_tb;

    localparam int TIMEOUT = 200;
    localparam logic [31:0] L0_BASE = 32'h0000_2000;

    logic                CLK;
    logic                arst_n;
    logic                cfg_we;
    logic [1:0]          cfg_sel;
    logic [31:0]         cfg_wdata;
    logic                req_valid;
    mmu_pkg::xlate_req_t req;
    logic                req_ready;
    logic                rsp_valid;
    mmu_pkg::xlate_rsp_t rsp;
    logic                mem_req_valid;
    mmu_pkg::mem_req_t   mem_req;
    logic                mem_credit;
    logic                mem_rsp_valid;
    logic [31:0]         mem_rsp_data;
    logic                hold_credit;

    int          errors = 0;
    int          tests = 0;
    int          test_start_errs = 0;
    int          reads = 0;
    int          writes = 0;
    int          out_cnt = 0;
    logic [31:0] last_waddr;
    logic [31:0] last_wdata;
    integer      seed = 32'h447b;

    mmu_pkg::xlate_rsp_t r;
    int          lat;
    int          rd0;
    int          wr0;
    logic [31:0] va;
    logic        bp_done;

    sv32_mmu UUT (.*);

    mem_model mem (.*);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // PTE word: 22-bit ppn, rsw zero, then D A G U X W R V
    function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    always @(posedge CLK) begin
        if (mem_req_valid) begin
            if (mem_req.we) begin
                writes     <= writes + 1;
                last_waddr <= mem_req.addr;
                last_wdata <= mem_req.wdata;
            end else begin
                reads <= reads + 1;
            end
        end
        out_cnt <= out_cnt + (mem_req_valid ? 1 : 0) - (mem_credit ? 1 : 0);
    end

    credit_bound: assert property (@(posedge CLK) disable iff (!arst_n)
        out_cnt <= mmu_pkg::MEM_CREDITS)
        else begin
            $display("outstanding memory requests above the credit limit");
            errors++;
        end

    single_rsp: assert property (@(posedge CLK) disable iff (!arst_n)
        rsp_valid |=> !rsp_valid)
        else begin
            $display("rsp_valid held for more than one cycle");
            errors++;
        end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act)
            else begin
                $display("[FAIL] %s expected %h actual %h", name, exp, act);
                errors++;
            end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out waiting for %s", what);
        errors++;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("%s: %0d errors", name, errors - test_start_errs);
        test_start_errs = errors;
    endtask

    task automatic write_cfg(input logic [1:0] sel, input logic [31:0] data);
        @(posedge CLK);
        cfg_we    <= 1'b1;
        cfg_sel   <= sel;
        cfg_wdata <= data;
        @(posedge CLK);
        cfg_we <= 1'b0;
        @(posedge CLK);
    endtask

    // lat counts cycles from acceptance to rsp_valid
    task automatic translate(input logic [31:0] vaddr, input mmu_pkg::acc_t acc,
                             output mmu_pkg::xlate_rsp_t res, output int cycles);
        int n;
        n = 0;
        @(negedge CLK);
        while (!req_ready && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        if (n >= TIMEOUT) report_timeout("req_ready");
        @(posedge CLK);
        req_valid  <= 1'b1;
        req.vaddr  <= vaddr;
        req.acc    <= acc;
        @(posedge CLK);
        req_valid <= 1'b0;
        cycles = 1;
        @(negedge CLK);
        while (!rsp_valid && cycles < TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (cycles >= TIMEOUT) report_timeout("rsp_valid");
        res = rsp;
    endtask

    task automatic wait_credits_home();
        int n;
        n = 0;
        while (out_cnt != 0 && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        if (n >= TIMEOUT) report_timeout("credit return");
    endtask

    task automatic expect_fault(input string name, input logic [3:0] cause);
        check_val({name, " fault"}, 32'd1, {31'd0, r.fault});
        check_val({name, " cause"}, {28'd0, cause}, {28'd0, r.cause});
    endtask

    initial begin
        arst_n      = 1'b0;
        cfg_we      = 1'b0;
        cfg_sel     = '0;
        cfg_wdata   = '0;
        req_valid   = 1'b0;
        req         = '0;
        hold_credit = 1'b0;
        @(posedge CLK);
        // root table at ppn 1, level-0 table at ppn 2
        mem.load_word(32'h1004, make_pte(22'h2, 8'h01));
        mem.load_word(32'h1008, make_pte({12'h0ab, 10'h0}, 8'hc7));
        mem.load_word(L0_BASE + 32'd12, make_pte(22'h12345, 8'h07));
        mem.load_word(L0_BASE + 32'd16, make_pte(22'h00456, 8'h03));
        mem.load_word(L0_BASE + 32'd20, make_pte(22'h00789, 8'h13));
        mem.load_word(L0_BASE + 32'd24, 32'h0);
        mem.load_word(L0_BASE + 32'd32, make_pte(22'h00abc, 8'h07));
        repeat (4) @(posedge CLK);
        arst_n <= 1'b1;

        // machine mode, then S mode with paging off
        va = $random(seed);
        translate(va, mmu_pkg::ACC_READ, r, lat);
        check_val("bypass M paddr", va, r.paddr);
        check_val("bypass M fault", 32'd0, {31'd0, r.fault});
        check_val("bypass M latency", 32'd1, lat);
        write_cfg(mmu_pkg::CFG_PRIV, {30'd0, mmu_pkg::PRIV_S});
        va = $random(seed);
        translate(va, mmu_pkg::ACC_CODE, r, lat);
        check_val("bypass S paddr", va, r.paddr);
        check_val("bypass S fault", 32'd0, {31'd0, r.fault});
        check_val("bypass S latency", 32'd1, lat);
        end_test("bypass");

        write_cfg(mmu_pkg::CFG_SATP, 32'h8000_0001);
        translate({10'd1, 10'd3, 12'h5a4}, mmu_pkg::ACC_READ, r, lat);
        check_val("4k read paddr", {20'h12345, 12'h5a4}, r.paddr);
        check_val("4k read A addr", L0_BASE + 32'd12, last_waddr);
        check_val("4k read A data", make_pte(22'h12345, 8'h47), last_wdata);
        wr0 = writes;
        translate({10'd1, 10'd3, 12'h010}, mmu_pkg::ACC_WRITE, r, lat);
        check_val("4k write paddr", {20'h12345, 12'h010}, r.paddr);
        check_val("4k write count", wr0 + 1, writes);
        check_val("4k write D data", make_pte(22'h12345, 8'hc7), last_wdata);
        end_test("translate_4k");

        for (int i = 0; i < 3; i++) begin
            va = {10'd2, 22'($random(seed))};
            rd0 = reads;
            translate(va, mmu_pkg::ACC_READ, r, lat);
            check_val("mega paddr", {10'h0ab, va[21:0]}, r.paddr);
            check_val("mega reads", rd0 + 1, reads);
            write_cfg(mmu_pkg::CFG_FENCE, 32'h0);
        end
        end_test("megapage");

        write_cfg(mmu_pkg::CFG_PRIV, {30'd0, mmu_pkg::PRIV_U});
        translate({10'd1, 10'd4, 12'h0}, mmu_pkg::ACC_READ, r, lat);
        expect_fault("user load", mmu_pkg::CAUSE_LOAD_PF);
        write_cfg(mmu_pkg::CFG_PRIV, {30'd0, mmu_pkg::PRIV_S});
        translate({10'd1, 10'd4, 12'h0}, mmu_pkg::ACC_WRITE, r, lat);
        expect_fault("store ro", mmu_pkg::CAUSE_STORE_PF);
        translate({10'd1, 10'd6, 12'h0}, mmu_pkg::ACC_CODE, r, lat);
        expect_fault("fetch invalid", mmu_pkg::CAUSE_FETCH_PF);
        translate({10'd1, 10'd5, 12'h0}, mmu_pkg::ACC_READ, r, lat);
        expect_fault("no sum", mmu_pkg::CAUSE_LOAD_PF);
        write_cfg(mmu_pkg::CFG_MSTATUS, 32'h0004_0000);
        translate({10'd1, 10'd5, 12'h77c}, mmu_pkg::ACC_READ, r, lat);
        check_val("sum paddr", {20'h00789, 12'h77c}, r.paddr);
        check_val("sum fault", 32'd0, {31'd0, r.fault});
        end_test("faults");

        translate({10'd1, 10'd3, 12'h100}, mmu_pkg::ACC_READ, r, lat);
        rd0 = reads + writes;
        translate({10'd1, 10'd3, 12'h104}, mmu_pkg::ACC_READ, r, lat);
        check_val("tlb hit paddr", {20'h12345, 12'h104}, r.paddr);
        check_val("tlb hit latency", 32'd1, lat);
        check_val("tlb hit mem reqs", rd0, reads + writes);
        write_cfg(mmu_pkg::CFG_FENCE, 32'h0);
        translate({10'd1, 10'd3, 12'h108}, mmu_pkg::ACC_READ, r, lat);
        check_val("flush paddr", {20'h12345, 12'h108}, r.paddr);
        check_val("flush rewalk reads", rd0 + 2, reads + writes);
        end_test("tlb_flush");

        wait_credits_home();
        @(posedge CLK);
        hold_credit <= 1'b1;
        bp_done = 1'b0;
        fork
            begin
                translate({10'd1, 10'd8, 12'h3c0}, mmu_pkg::ACC_READ, r, lat);
                bp_done = 1'b1;
            end
            begin
                repeat (12) @(negedge CLK);
                check_val("bp outstanding", mmu_pkg::MEM_CREDITS, out_cnt);
                check_val("bp mem_req_valid", 32'd0, {31'd0, mem_req_valid});
                check_val("bp pending", 32'd0, {31'd0, bp_done});
                @(posedge CLK);
                hold_credit <= 1'b0;
            end
        join
        check_val("bp paddr", {20'h00abc, 12'h3c0}, r.paddr);
        check_val("bp fault", 32'd0, {31'd0, r.fault});
        end_test("backpressure");

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* test/mem_model.sv */
////////////////////////////////////////////////////////////
// page-table memory for the MMU testbench: in-order read
// responses, delayed credit return that can be withheld
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mem_model (
    input  logic               CLK,
    input  logic               arst_n,
    input  logic               hold_credit,
    input  logic               mem_req_valid,
    input  mmu_pkg::mem_req_t  mem_req,
    output logic               mem_credit,
    output logic               mem_rsp_valid,
    output logic [31:0]        mem_rsp_data
);

    localparam int WORDS = 4096;

    logic [31:0] words [WORDS];
    logic [3:0]  pend;
    logic [1:0]  timer;

    // background words all have V clear so stray walks fault
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            words[i] = {4'hc, 12'(i), 12'(i), 4'h0};
        end
    end

    task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
        words[addr[13:2]] = data;
    endtask

    // one credit back every few cycles per outstanding request
    always @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            pend       <= '0;
            timer      <= '0;
            mem_credit <= 1'b0;
        end else begin
            if (mem_req_valid && !mem_credit) begin
                pend <= pend + 4'd1;
            end else if (mem_credit && !mem_req_valid) begin
                pend <= pend - 4'd1;
            end
            mem_credit <= 1'b0;
            if (hold_credit || pend == 4'd0 || (pend == 4'd1 && mem_credit)) begin
                timer <= '0;
            end else if (timer == 2'd2) begin
                timer      <= '0;
                mem_credit <= 1'b1;
            end else begin
                timer <= timer + 2'd1;
            end
        end
    end

    always @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            mem_rsp_valid <= 1'b0;
            mem_rsp_data  <= '0;
        end else begin
            mem_rsp_valid <= 1'b0;
            if (mem_req_valid) begin
                if (mem_req.we) begin
                    words[mem_req.addr[13:2]] <= mem_req.wdata;
                end else begin
                    mem_rsp_valid <= 1'b1;
                    mem_rsp_data  <= words[mem_req.addr[13:2]];
                end
            end
        end
    end

endmodule

/* hw/sv32_mmu.sv */
////////////////////////////////////////////////////////////
// Sv32 MMU top: config registers, one TLB per access type
// and the page walker behind a credit-based memory port
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sv32_mmu (
    input  logic                 CLK,
    input  logic                 arst_n,
    input  logic                 cfg_we,
    input  logic [1:0]           cfg_sel,
    input  logic [31:0]          cfg_wdata,
    input  logic                 req_valid,
    input  mmu_pkg::xlate_req_t  req,
    output logic                 req_ready,
    output logic                 rsp_valid,
    output mmu_pkg::xlate_rsp_t  rsp,
    output logic                 mem_req_valid,
    output mmu_pkg::mem_req_t    mem_req,
    input  logic                 mem_credit,
    input  logic                 mem_rsp_valid,
    input  logic [31:0]          mem_rsp_data
);

    mmu_pkg::xlate_cfg_t cfg;
    mmu_pkg::acc_t       fill_acc;
    logic                tlb_flush;
    logic                fill_we;
    logic [19:0]         fill_vpn;
    logic [19:0]         fill_ppn;
    logic [19:0]         lookup_vpn;
    logic                hit_code, hit_read, hit_write, sel_hit;
    logic [19:0]         ppn_code, ppn_read, ppn_write, sel_ppn;

    assign lookup_vpn = {req.vaddr.page.vpn1, req.vaddr.page.vpn0};

    mmu_ctrl_regs u_ctrl_regs (
        .CLK, .arst_n, .cfg_we, .cfg_sel, .cfg_wdata, .cfg, .tlb_flush
    );

    tlb tlb_code (
        .CLK, .arst_n, .flush (tlb_flush), .lookup_vpn,
        .fill_we (fill_we && fill_acc == mmu_pkg::ACC_CODE),
        .fill_vpn, .fill_ppn, .hit (hit_code), .hit_ppn (ppn_code)
    );

    tlb tlb_read (
        .CLK, .arst_n, .flush (tlb_flush), .lookup_vpn,
        .fill_we (fill_we && fill_acc == mmu_pkg::ACC_READ),
        .fill_vpn, .fill_ppn, .hit (hit_read), .hit_ppn (ppn_read)
    );

    tlb tlb_write (
        .CLK, .arst_n, .flush (tlb_flush), .lookup_vpn,
        .fill_we (fill_we && fill_acc == mmu_pkg::ACC_WRITE),
        .fill_vpn, .fill_ppn, .hit (hit_write), .hit_ppn (ppn_write)
    );

    // only the TLB of the requested access type may answer
    always_comb begin
        case (req.acc)
            mmu_pkg::ACC_CODE:  {sel_hit, sel_ppn} = {hit_code, ppn_code};
            mmu_pkg::ACC_READ:  {sel_hit, sel_ppn} = {hit_read, ppn_read};
            mmu_pkg::ACC_WRITE: {sel_hit, sel_ppn} = {hit_write, ppn_write};
            default:            {sel_hit, sel_ppn} = '0;
        endcase
    end

    page_walker u_walker (
        .CLK, .arst_n, .req_valid, .req, .cfg,
        .tlb_hit (sel_hit), .tlb_ppn (sel_ppn),
        .mem_credit, .mem_rsp_valid, .mem_rsp_data,
        .req_ready, .rsp_valid, .rsp,
        .fill_we, .fill_acc, .fill_vpn, .fill_ppn,
        .mem_req_valid, .mem_req
    );

endmodule

/* hw/page_walker.sv */
////////////////////////////////////////////////////////////
// Sv32 walk FSM: bypass, TLB hit answer, two-level walk,
// A/D write-back and TLB fill, credit-based PTE memory port
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module page_walker (
    input  logic                 CLK,
    input  logic                 arst_n,
    input  logic                 req_valid,
    input  mmu_pkg::xlate_req_t  req,
    input  mmu_pkg::xlate_cfg_t  cfg,
    input  logic                 tlb_hit,
    input  logic [19:0]          tlb_ppn,
    input  logic                 mem_credit,
    input  logic                 mem_rsp_valid,
    input  logic [31:0]          mem_rsp_data,
    output logic                 req_ready,
    output logic                 rsp_valid,
    output mmu_pkg::xlate_rsp_t  rsp,
    output logic                 fill_we,
    output mmu_pkg::acc_t        fill_acc,
    output logic [19:0]          fill_vpn,
    output logic [19:0]          fill_ppn,
    output logic                 mem_req_valid,
    output mmu_pkg::mem_req_t    mem_req
);

    typedef enum logic [2:0] {
        S_IDLE, S_L1_RD, S_L1_WAIT, S_L0_RD, S_L0_WAIT, S_UPDATE, S_RESPOND
    } state_t;

    state_t                    state_q;
    mmu_pkg::xlate_req_t       req_q;
    mmu_pkg::xlate_rsp_t       rsp_q;
    mmu_pkg::pte_t             pte_q;
    logic [31:0]               ptea_q;
    logic                      walk_ok_q;
    logic [mmu_pkg::CRED_W-1:0] cred_q;

    mmu_pkg::pte_t rd_pte;
    mmu_pkg::pte_t chk_upd_pte;
    logic          chk_leaf;
    logic          chk_allow;
    logic          chk_need_upd;
    logic          accept;
    logic          bypass;
    logic          pte_in;
    logic          descend;
    logic          grant;
    logic [3:0]    fault_cause;

    assign rd_pte = mem_rsp_data;

    // one checker serves both levels, it only ever sees the returning PTE
    pte_check u_pte_check (
        .pte         (rd_pte),
        .acc         (req_q.acc),
        .cfg         (cfg),
        .leaf        (chk_leaf),
        .allow       (chk_allow),
        .need_update (chk_need_upd),
        .pte_upd     (chk_upd_pte)
    );

    assign req_ready = (state_q == S_IDLE);
    assign accept    = req_valid && req_ready;
    assign bypass    = (cfg.priv == mmu_pkg::PRIV_M) || !cfg.enable;
    assign pte_in    = mem_rsp_valid && (state_q == S_L1_WAIT || state_q == S_L0_WAIT);
    assign descend   = (state_q == S_L1_WAIT) && rd_pte.v && !chk_leaf;
    assign grant     = chk_leaf && chk_allow;

    assign rsp_valid = (state_q == S_RESPOND);
    assign rsp       = rsp_q;
    assign fill_we   = rsp_valid && walk_ok_q;
    assign fill_acc  = req_q.acc;
    assign fill_vpn  = {req_q.vaddr.page.vpn1, req_q.vaddr.page.vpn0};
    assign fill_ppn  = rsp_q.paddr[31:12];

    // requests only go out while a credit is held
    assign mem_req_valid = (state_q == S_L1_RD || state_q == S_L0_RD || state_q == S_UPDATE) &&
                           cred_q != '0;
    assign mem_req = '{addr: ptea_q, wdata: pte_q, we: (state_q == S_UPDATE)};

    always_comb begin
        case (req_q.acc)
            mmu_pkg::ACC_CODE: fault_cause = mmu_pkg::CAUSE_FETCH_PF;
            mmu_pkg::ACC_READ: fault_cause = mmu_pkg::CAUSE_LOAD_PF;
            default:           fault_cause = mmu_pkg::CAUSE_STORE_PF;
        endcase
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            cred_q <= mmu_pkg::MEM_CREDITS[mmu_pkg::CRED_W-1:0];
        end else if (mem_req_valid && !mem_credit) begin
            cred_q <= cred_q - 1'b1;
        end else if (mem_credit && !mem_req_valid) begin
            cred_q <= cred_q + 1'b1;
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= S_IDLE;
            walk_ok_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (accept) begin
                        walk_ok_q <= 1'b0;
                        state_q   <= (bypass || tlb_hit) ? S_RESPOND : S_L1_RD;
                    end
                end
                S_L1_RD: if (mem_req_valid) state_q <= S_L1_WAIT;
                S_L0_RD: if (mem_req_valid) state_q <= S_L0_WAIT;
                S_L1_WAIT, S_L0_WAIT: begin
                    if (pte_in) begin
                        if (descend) begin
                            state_q <= S_L0_RD;
                        end else if (grant) begin
                            walk_ok_q <= 1'b1;
                            state_q   <= chk_need_upd ? S_UPDATE : S_RESPOND;
                        end else begin
                            state_q <= S_RESPOND;
                        end
                    end
                end
                S_UPDATE: if (mem_req_valid) state_q <= S_RESPOND;
                default:  state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            req_q       <= req;
            ptea_q      <= {cfg.root_ppn, 12'h000} + {20'h0, req.vaddr.page.vpn1, 2'b00};
            rsp_q.fault <= 1'b0;
            rsp_q.cause <= '0;
            rsp_q.paddr <= bypass ? req.vaddr : {tlb_ppn, req.vaddr.page.offset};
        end else if (pte_in) begin
            pte_q <= chk_upd_pte;
            if (descend) begin
                ptea_q <= {rd_pte.ppn1[9:0], rd_pte.ppn0, 12'h000} +
                          {20'h0, req_q.vaddr.page.vpn0, 2'b00};
            end else if (grant && state_q == S_L1_WAIT) begin
                // megapage keeps vpn0 and the offset from the virtual address
                rsp_q.paddr <= {rd_pte.ppn1[9:0], req_q.vaddr.mega.offset};
            end else if (grant) begin
                rsp_q.paddr <= {rd_pte.ppn1[9:0], rd_pte.ppn0, req_q.vaddr.page.offset};
            end else begin
                rsp_q.paddr <= '0;
                rsp_q.fault <= 1'b1;
                rsp_q.cause <= fault_cause;
            end
        end
    end

endmodule

/* hw/pte_check.sv */
////////////////////////////////////////////////////////////
// permission check of one fetched PTE against the access,
// plus the A/D updated word for write-back
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pte_check (
    input  mmu_pkg::pte_t        pte,
    input  mmu_pkg::acc_t        acc,
    input  mmu_pkg::xlate_cfg_t  cfg,
    output logic                 leaf,
    output logic                 allow,
    output logic                 need_update,
    output mmu_pkg::pte_t        pte_upd
);

    logic [2:0] xwr;
    logic       reserved;
    logic       read_ok;
    logic       perm;
    logic       priv_ok;

    always_comb begin
        xwr  = {pte.x, pte.w, pte.r};
        leaf = |xwr;

        // write without read is a reserved encoding
        reserved = (xwr == 3'b010) || (xwr == 3'b110);

        // MXR makes executable pages readable
        read_ok = pte.r || (cfg.mxr && pte.x);

        case (acc)
            mmu_pkg::ACC_READ:  perm = read_ok;
            mmu_pkg::ACC_WRITE: perm = pte.w;
            mmu_pkg::ACC_CODE:  perm = pte.x;
            default:            perm = 1'b0;
        endcase

        priv_ok = !((cfg.priv == mmu_pkg::PRIV_U && !pte.u) ||
                    (cfg.priv == mmu_pkg::PRIV_S && pte.u && !cfg.sum));

        allow = pte.v && !reserved && priv_ok && perm;

        // accessed always, dirty only on stores
        pte_upd = pte;
        pte_upd[mmu_pkg::PTE_A_BIT] = 1'b1;
        if (acc == mmu_pkg::ACC_WRITE) begin
            pte_upd[mmu_pkg::PTE_D_BIT] = 1'b1;
        end

        need_update = (pte_upd != pte);
    end

endmodule

/* hw/tlb.sv */
////////////////////////////////////////////////////////////
// direct-mapped TLB for one access type
// lookup is combinational, fills land on the next edge
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tlb (
    input  logic        CLK,
    input  logic        arst_n,
    input  logic        flush,
    input  logic [19:0] lookup_vpn,
    input  logic        fill_we,
    input  logic [19:0] fill_vpn,
    input  logic [19:0] fill_ppn,
    output logic        hit,
    output logic [19:0] hit_ppn
);

    logic [mmu_pkg::TLB_TAG_W-1:0]   tag_q [mmu_pkg::TLB_ENTRIES];
    logic [19:0]                     ppn_q [mmu_pkg::TLB_ENTRIES];
    logic [mmu_pkg::TLB_ENTRIES-1:0] valid_q;

    logic [mmu_pkg::TLB_IDX_W-1:0] rd_idx;
    logic [mmu_pkg::TLB_IDX_W-1:0] wr_idx;

    // low VPN bits pick the entry, the rest is the tag
    assign rd_idx = lookup_vpn[mmu_pkg::TLB_IDX_W-1:0];
    assign wr_idx = fill_vpn[mmu_pkg::TLB_IDX_W-1:0];

    assign hit     = valid_q[rd_idx] &&
                     tag_q[rd_idx] == lookup_vpn[19:mmu_pkg::TLB_IDX_W];
    assign hit_ppn = ppn_q[rd_idx];

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (flush) begin
            // flush wins over a coincident fill
            valid_q <= '0;
        end else if (fill_we) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (fill_we) begin
            tag_q[wr_idx] <= fill_vpn[19:mmu_pkg::TLB_IDX_W];
            ppn_q[wr_idx] <= fill_ppn;
        end
    end

endmodule

/* hw/mmu_ctrl_regs.sv */
////////////////////////////////////////////////////////////
// translation configuration registers: satp, privilege,
// SUM and MXR; satp and fence writes flush the TLBs
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mmu_ctrl_regs (
    input  logic                 CLK,
    input  logic                 arst_n,
    input  logic                 cfg_we,
    input  logic [1:0]           cfg_sel,
    input  logic [31:0]          cfg_wdata,
    output mmu_pkg::xlate_cfg_t  cfg,
    output logic                 tlb_flush
);

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            cfg.enable   <= 1'b0;
            cfg.root_ppn <= '0;
            // core leaves reset in machine mode
            cfg.priv     <= mmu_pkg::PRIV_M;
            cfg.sum      <= 1'b0;
            cfg.mxr      <= 1'b0;
            tlb_flush    <= 1'b0;
        end else begin
            // new root or explicit fence invalidates all cached translations
            tlb_flush <= cfg_we && (cfg_sel == mmu_pkg::CFG_SATP ||
                                    cfg_sel == mmu_pkg::CFG_FENCE);
            if (cfg_we) begin
                case (cfg_sel)
                    mmu_pkg::CFG_SATP: begin
                        cfg.enable   <= cfg_wdata[mmu_pkg::SATP_MODE_BIT];
                        cfg.root_ppn <= cfg_wdata[19:0];
                    end
                    mmu_pkg::CFG_PRIV: begin
                        cfg.priv <= cfg_wdata[1:0];
                    end
                    mmu_pkg::CFG_MSTATUS: begin
                        cfg.sum <= cfg_wdata[mmu_pkg::MSTATUS_SUM_BIT];
                        cfg.mxr <= cfg_wdata[mmu_pkg::MSTATUS_MXR_BIT];
                    end
                    // fence only flushes
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

/* hw/mmu_pkg.sv */
////////////////////////////////////////////////////////////
// constants and types shared by the Sv32 MMU RTL
// every file refers to them by mmu_pkg:: scoped names
////////////////////////////////////////////////////////////
package mmu_pkg;

    // TLB geometry
    localparam int TLB_ENTRIES = 4;
    localparam int TLB_IDX_W   = $clog2(TLB_ENTRIES);
    localparam int TLB_TAG_W   = 20 - TLB_IDX_W;

    // credits granted by the PTE memory out of reset
    localparam int MEM_CREDITS = 2;
    localparam int CRED_W      = $clog2(MEM_CREDITS + 1);

    typedef logic [1:0] acc_t;

    // encoding follows the R/W/X bit order of a PTE
    localparam acc_t ACC_READ  = 2'd0;
    localparam acc_t ACC_WRITE = 2'd1;
    localparam acc_t ACC_CODE  = 2'd2;

    localparam logic [1:0] PRIV_U = 2'd0;
    localparam logic [1:0] PRIV_S = 2'd1;
    localparam logic [1:0] PRIV_M = 2'd3;

    localparam logic [3:0] CAUSE_FETCH_PF = 4'd12;
    localparam logic [3:0] CAUSE_LOAD_PF  = 4'd13;
    localparam logic [3:0] CAUSE_STORE_PF = 4'd15;

    localparam int PTE_A_BIT = 6;
    localparam int PTE_D_BIT = 7;

    // configuration port selects and register fields
    localparam logic [1:0] CFG_SATP    = 2'd0;
    localparam logic [1:0] CFG_PRIV    = 2'd1;
    localparam logic [1:0] CFG_MSTATUS = 2'd2;
    localparam logic [1:0] CFG_FENCE   = 2'd3;
    localparam int SATP_MODE_BIT   = 31;
    localparam int MSTATUS_SUM_BIT = 18;
    localparam int MSTATUS_MXR_BIT = 19;

    typedef struct packed {
        logic [9:0]  vpn1;
        logic [9:0]  vpn0;
        logic [11:0] offset;
    } va_page_t;

    typedef struct packed {
        logic [9:0]  vpn1;
        logic [21:0] offset;
    } va_mega_t;

    // one virtual address, read as a 4 KiB page or as a megapage
    typedef union packed {
        va_page_t page;
        va_mega_t mega;
    } va_u;

    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } pte_t;

    typedef struct packed {
        logic        enable;
        logic [19:0] root_ppn;
        logic [1:0]  priv;
        logic        sum;
        logic        mxr;
    } xlate_cfg_t;

    typedef struct packed {
        va_u  vaddr;
        acc_t acc;
    } xlate_req_t;

    typedef struct packed {
        logic [31:0] paddr;
        logic        fault;
        logic [3:0]  cause;
    } xlate_rsp_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
    } mem_req_t;

endpackage
